// ==== bignum.f ====
verilog/bignum_pkg.sv
verilog/mem_bus_if.sv
verilog/add_sub_unit.sv
verilog/mul_unit.sv
verilog/op_dispatch.sv
verilog/bignum_top.sv
sim/bignum_sva.sv
sim/tb_bignum.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_bignum
FILELIST   := bignum.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0
OBJ_DIR    := obj_dir
PASS_MSG   := *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/tb_bignum.sv ====
`timescale 1ns/100ps

module tb_bignum;
    import bignum_pkg::*;

    localparam int N_OPS      = 40;
    localparam int OP_CYCLES  = 300;
    localparam int CLK_NS     = 10;
    localparam int TIMEOUT_NS = N_OPS * OP_CYCLES * CLK_NS;
    localparam int MEM_DEPTH  = 1024;
    localparam int MAX_LEN    = 8;

    typedef logic [MAX_LEN*WORD_W-1:0]   opnd_t;
    typedef logic [2*MAX_LEN*WORD_W-1:0] rslt_t;

    logic  i_clk;
    logic  i_rst_n;
    logic  i_req_valid;
    logic  o_req_ready;
    op_e   i_req_op;
    addr_t i_req_a_addr;
    addr_t i_req_b_addr;
    addr_t i_req_dst_addr;
    len_t  i_req_a_len;
    len_t  i_req_b_len;
    logic  o_rsp_valid;
    logic  i_rsp_ready;
    len_t  o_rsp_len;
    addr_t o_mem_addr;
    logic  o_mem_we;
    word_t o_mem_wdata;
    word_t i_mem_rdata;

    word_t       mem     [MEM_DEPTH];
    word_t       exp_mem [MEM_DEPTH]; // what memory should hold.
    opnd_t       a_vec;
    opnd_t       b_vec;
    rslt_t       ref_vec;
    int          exp_len;
    logic        load_req;
    logic [31:0] rng          = 32'hfd6a;
    int          mismatch_cnt = 0;
    int          proto_cnt    = 0;
    event        check_ev;

    bignum_top i_bignum_top (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_req_valid    (i_req_valid),
        .o_req_ready    (o_req_ready),
        .i_req_op       (i_req_op),
        .i_req_a_addr   (i_req_a_addr),
        .i_req_b_addr   (i_req_b_addr),
        .i_req_dst_addr (i_req_dst_addr),
        .i_req_a_len    (i_req_a_len),
        .i_req_b_len    (i_req_b_len),
        .o_rsp_valid    (o_rsp_valid),
        .i_rsp_ready    (i_rsp_ready),
        .o_rsp_len      (o_rsp_len),
        .o_mem_addr     (o_mem_addr),
        .o_mem_we       (o_mem_we),
        .o_mem_wdata    (o_mem_wdata),
        .i_mem_rdata    (i_mem_rdata)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_NS / 2) i_clk = ~i_clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout after %0d ns, the DUT stopped answering", TIMEOUT_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

    function automatic word_t fill_word(input addr_t addr);
        logic [31:0] h;
        h = 32'(addr) * 32'h9e37_79b1;
        return h[31:16] ^ word_t'(addr);
    endfunction

    // async read, write on the rising edge.
    assign i_mem_rdata = mem[o_mem_addr[9:0]];

    always @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem[i] <= fill_word(addr_t'(i));
            end
        end else if (o_mem_we) begin
            mem[o_mem_addr[9:0]] <= o_mem_wdata;
        end else if (load_req) begin
            for (int i = 0; i < MAX_LEN; i++) begin
                if (i < int'(i_req_a_len)) begin
                    mem[10'(i_req_a_addr + addr_t'(i))] <= a_vec[i*WORD_W +: WORD_W];
                end
                if (i < int'(i_req_b_len)) begin
                    mem[10'(i_req_b_addr + addr_t'(i))] <= b_vec[i*WORD_W +: WORD_W];
                end
            end
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic int bignum_ref(input op_e op, input int a_len, input int b_len,
                                      input opnd_t a, input opnd_t b, output rslt_t r);
        int          n;
        int          cnt;
        word_t       aw;
        word_t       bw;
        logic [16:0] sum;
        logic        c;
        logic [47:0] col;
        n   = (a_len > b_len) ? a_len : b_len;
        r   = '0;
        c   = 1'b0;
        col = '0;
        if (op == OP_MUL) begin
            // column sums with the carry moving up one word.
            for (int k = 0; k < a_len + b_len; k++) begin
                for (int i = 0; i < a_len; i++) begin
                    if (k - i >= 0 && k - i < b_len) begin
                        col = col + 48'(a[i*WORD_W +: WORD_W])
                                  * 48'(b[(k-i)*WORD_W +: WORD_W]);
                    end
                end
                r[k*WORD_W +: WORD_W] = col[WORD_W-1:0];
                col = col >> WORD_W;
            end
            cnt = a_len + b_len;
        end else begin
            for (int i = 0; i < n; i++) begin
                aw = (i < a_len) ? a[i*WORD_W +: WORD_W] : '0;
                bw = (i < b_len) ? b[i*WORD_W +: WORD_W] : '0;
                if (op == OP_SUB) begin
                    sum = {1'b0, aw} - {1'b0, bw} - 17'(c); // bit 16 is the borrow.
                end else begin
                    sum = {1'b0, aw} + {1'b0, bw} + 17'(c);
                end
                r[i*WORD_W +: WORD_W] = sum[WORD_W-1:0];
                c = sum[WORD_W];
            end
            cnt = n;
            if (op == OP_ADD) begin
                r[n*WORD_W +: WORD_W] = word_t'(c);
                cnt = n + 1;
            end
        end
        return cnt;
    endfunction

    task automatic build_operands(input int k);
        logic all_ones;
        int   a_len;
        int   b_len;
        op_e  op;
        all_ones = (k == 0 || k == 3);
        a_len    = int'(next_rand() % 32'd8) + 1;
        b_len    = int'(next_rand() % 32'd8) + 1;
        op       = op_e'(2'(next_rand() % 32'd3));
        case (k)
            0: begin
                op    = OP_ADD;
                b_len = a_len;
            end
            1: begin
                op    = OP_SUB;
                a_len = 2;
                b_len = 5;
            end
            2: begin
                op    = OP_MUL;
                a_len = 1;
                b_len = 1;
            end
            3: begin
                op    = OP_MUL;
                a_len = MAX_LEN;
                b_len = MAX_LEN;
            end
            default: ;
        endcase
        for (int i = 0; i < MAX_LEN; i++) begin
            a_vec[i*WORD_W +: WORD_W] = '0;
            b_vec[i*WORD_W +: WORD_W] = '0;
            if (i < a_len) a_vec[i*WORD_W +: WORD_W] = all_ones ? 16'hffff : word_t'(next_rand());
            if (i < b_len) b_vec[i*WORD_W +: WORD_W] = all_ones ? 16'hffff : word_t'(next_rand());
        end
        if (k == 1) b_vec[4*WORD_W +: WORD_W] = b_vec[4*WORD_W +: WORD_W] | 16'h8000; // b > a.
        i_req_op       = op;
        i_req_a_len    = len_t'(a_len);
        i_req_b_len    = len_t'(b_len);
        i_req_a_addr   = 20'h00100 + addr_t'(next_rand() % 32'd64);
        i_req_b_addr   = 20'h00200 + addr_t'(next_rand() % 32'd64);
        i_req_dst_addr = 20'h00300 + addr_t'(next_rand() % 32'd64);
        exp_len        = bignum_ref(op, a_len, b_len, a_vec, b_vec, ref_vec);
        for (int i = 0; i < a_len; i++) begin
            exp_mem[10'(i_req_a_addr + addr_t'(i))] = a_vec[i*WORD_W +: WORD_W];
        end
        for (int i = 0; i < b_len; i++) begin
            exp_mem[10'(i_req_b_addr + addr_t'(i))] = b_vec[i*WORD_W +: WORD_W];
        end
        for (int i = 0; i < exp_len; i++) begin
            exp_mem[10'(i_req_dst_addr + addr_t'(i))] = ref_vec[i*WORD_W +: WORD_W];
        end
    endtask

    task automatic check_stall(input len_t exp_rsp_len);
        assert (o_rsp_valid) else begin
            proto_cnt++;
            $display("o_rsp_valid dropped before the response was taken");
        end
        assert (o_rsp_len == exp_rsp_len) else begin
            proto_cnt++;
            $display("Mismatch o_rsp_len: got %h expected %h", o_rsp_len, exp_rsp_len);
        end
        assert (!o_mem_we) else begin
            proto_cnt++;
            $display("memory write while the response was waiting");
        end
        assert (!o_req_ready) else begin
            proto_cnt++;
            $display("o_req_ready high while the response was waiting");
        end
    endtask

    task automatic check_idle();
        assert (!o_rsp_valid && !o_mem_we && o_req_ready) else begin
            proto_cnt++;
            $display("DUT not idle after reset");
        end
    endtask

    task automatic run_request();
        int hold;
        load_req = 1'b1;
        @(negedge i_clk);
        load_req    = 1'b0;
        i_req_valid = 1'b1;
        while (!o_req_ready) @(negedge i_clk);
        @(negedge i_clk);
        i_req_valid = 1'b0;
        while (!o_rsp_valid) @(negedge i_clk);
        hold = int'(next_rand() % 32'd12);
        repeat (hold) begin
            check_stall(len_t'(exp_len));
            @(negedge i_clk);
        end
        -> check_ev;
        i_rsp_ready = 1'b1;
        @(negedge i_clk);
        i_rsp_ready = 1'b0;
    endtask

    // whole memory against the model.
    always @(check_ev) begin
        assert (o_rsp_len == len_t'(exp_len)) else begin
            mismatch_cnt++;
            $display("Mismatch o_rsp_len: got %h expected %h", o_rsp_len, len_t'(exp_len));
        end
        for (int i = 0; i < MEM_DEPTH; i++) begin
            assert (mem[i] == exp_mem[i]) else begin
                mismatch_cnt++;
                $display("Mismatch mem[%h]: got %h expected %h", 10'(i), mem[i], exp_mem[i]);
            end
        end
    end

    initial begin
        i_rst_n        = 1'b0;
        i_req_valid    = 1'b0;
        i_req_op       = OP_ADD;
        i_req_a_addr   = '0;
        i_req_b_addr   = '0;
        i_req_dst_addr = '0;
        i_req_a_len    = 8'd1;
        i_req_b_len    = 8'd1;
        i_rsp_ready    = 1'b0;
        load_req       = 1'b0;
        for (int i = 0; i < MEM_DEPTH; i++) exp_mem[i] = fill_word(addr_t'(i));
        repeat (16) @(negedge i_clk);
        i_rst_n = 1'b1;
        @(negedge i_clk);
        check_idle();
        for (int k = 0; k < N_OPS; k++) begin
            build_operands(k);
            run_request();
        end
        @(negedge i_clk);
        $display("result mismatches: %0d, handshake errors: %0d", mismatch_cnt, proto_cnt);
        if (mismatch_cnt == 0 && proto_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== sim/bignum_sva.sv ====
`timescale 1ns/100ps

module bignum_sva (
    input logic             i_clk,
    input logic             i_rst_n,
    input logic             i_req_ready,
    input logic             i_rsp_valid,
    input logic             i_rsp_ready,
    input bignum_pkg::len_t i_rsp_len,
    input logic             i_mem_we,
    input logic             i_busy,
    input logic             i_accept,
    input logic             i_add_start,
    input logic             i_mul_start
);

    rsp_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_rsp_valid && !i_rsp_ready |=> i_rsp_valid && $stable(i_rsp_len))
        else $error("response dropped or changed under back-pressure");

    ready_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_req_ready && i_rsp_valid))
        else $error("request ready and response valid high together");

    we_in_run: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_mem_we |-> i_busy)
        else $error("memory write outside a running unit");

    // a unit starts only right after an accept.
    start_after_accept: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_add_start || i_mul_start) |-> $past(i_accept))
        else $error("unit start without a preceding accept");

endmodule

bind op_dispatch bignum_sva i_bignum_sva (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_req_ready (o_req_ready),
    .i_rsp_valid (o_rsp_valid),
    .i_rsp_ready (i_rsp_ready),
    .i_rsp_len   (o_rsp_len),
    .i_mem_we    (o_mem_we),
    .i_busy      (state == RUN_ADD || state == RUN_MUL),
    .i_accept    (accept),
    .i_add_start (o_add_start),
    .i_mul_start (o_mul_start)
);

// ==== verilog/bignum_top.sv ====
`timescale 1ns/100ps

module bignum_top (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_req_valid,
    output logic              o_req_ready,
    input  bignum_pkg::op_e   i_req_op,
    input  bignum_pkg::addr_t i_req_a_addr,
    input  bignum_pkg::addr_t i_req_b_addr,
    input  bignum_pkg::addr_t i_req_dst_addr,
    input  bignum_pkg::len_t  i_req_a_len,
    input  bignum_pkg::len_t  i_req_b_len,
    output logic              o_rsp_valid,
    input  logic              i_rsp_ready,
    output bignum_pkg::len_t  o_rsp_len,
    output bignum_pkg::addr_t o_mem_addr,
    output logic              o_mem_we,
    output bignum_pkg::word_t o_mem_wdata,
    input  bignum_pkg::word_t i_mem_rdata
);
    import bignum_pkg::*;

    op_req_t req;
    op_req_t req_q; // held by the dispatcher while a unit runs.
    logic    add_start;
    logic    sub;
    logic    add_done;
    logic    mul_start;
    logic    mul_done;

    mem_bus_if add_bus ();
    mem_bus_if mul_bus ();

    assign req = '{
        op:       i_req_op,
        a_addr:   i_req_a_addr,
        b_addr:   i_req_b_addr,
        dst_addr: i_req_dst_addr,
        a_len:    i_req_a_len,
        b_len:    i_req_b_len
    };

    op_dispatch i_op_dispatch (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_req_valid (i_req_valid),
        .o_req_ready (o_req_ready),
        .i_req       (req),
        .o_rsp_valid (o_rsp_valid),
        .i_rsp_ready (i_rsp_ready),
        .o_rsp_len   (o_rsp_len),
        .o_add_start (add_start),
        .o_sub       (sub),
        .i_add_done  (add_done),
        .o_mul_start (mul_start),
        .i_mul_done  (mul_done),
        .o_req       (req_q),
        .add_bus     (add_bus.arbiter),
        .mul_bus     (mul_bus.arbiter),
        .o_mem_addr  (o_mem_addr),
        .o_mem_we    (o_mem_we),
        .o_mem_wdata (o_mem_wdata),
        .i_mem_rdata (i_mem_rdata)
    );

    add_sub_unit i_add_sub_unit (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_start (add_start),
        .i_sub   (sub),
        .i_req   (req_q),
        .o_done  (add_done),
        .bus     (add_bus.master)
    );

    mul_unit i_mul_unit (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_start (mul_start),
        .i_req   (req_q),
        .o_done  (mul_done),
        .bus     (mul_bus.master)
    );

endmodule

// ==== verilog/op_dispatch.sv ====
`timescale 1ns/100ps

module op_dispatch (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_req_valid,
    output logic                o_req_ready,
    input  bignum_pkg::op_req_t i_req,
    output logic                o_rsp_valid,
    input  logic                i_rsp_ready,
    output bignum_pkg::len_t    o_rsp_len,
    output logic                o_add_start,
    output logic                o_sub,
    input  logic                i_add_done,
    output logic                o_mul_start,
    input  logic                i_mul_done,
    output bignum_pkg::op_req_t o_req,
    mem_bus_if.arbiter          add_bus,
    mem_bus_if.arbiter          mul_bus,
    output bignum_pkg::addr_t   o_mem_addr,
    output logic                o_mem_we,
    output bignum_pkg::word_t   o_mem_wdata,
    input  bignum_pkg::word_t   i_mem_rdata
);
    import bignum_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        RUN_ADD,
        RUN_MUL,
        RESPOND
    } state_e;

    state_e  state;
    op_req_t req_q;
    len_t    rsp_len_q;
    len_t    rsp_len;
    len_t    max_len;
    logic    add_start_q;
    logic    mul_start_q;
    logic    accept;
    logic    unit_done;

    assign o_req_ready = (state == IDLE);
    assign o_rsp_valid = (state == RESPOND);
    assign o_rsp_len   = rsp_len_q;
    assign o_add_start = add_start_q;
    assign o_mul_start = mul_start_q;
    assign o_req       = req_q;
    assign o_sub       = (req_q.op == OP_SUB);
    assign accept      = i_req_valid && o_req_ready;
    assign unit_done   = (state == RUN_ADD && i_add_done) || (state == RUN_MUL && i_mul_done);

    always_comb begin
        max_len = (req_q.a_len > req_q.b_len) ? req_q.a_len : req_q.b_len;
        case (req_q.op)
            OP_SUB:  rsp_len = max_len;
            OP_MUL:  rsp_len = req_q.a_len + req_q.b_len;
            default: rsp_len = max_len + len_t'(1); // add keeps the carry word.
        endcase
    end

    // only the running unit reaches memory.
    always_comb begin
        o_mem_addr    = '0;
        o_mem_we      = 1'b0;
        o_mem_wdata   = '0;
        add_bus.rdata = '0;
        mul_bus.rdata = '0;
        case (state)
            RUN_ADD: begin
                o_mem_addr    = add_bus.addr;
                o_mem_we      = add_bus.we;
                o_mem_wdata   = add_bus.wdata;
                add_bus.rdata = i_mem_rdata;
            end
            RUN_MUL: begin
                o_mem_addr    = mul_bus.addr;
                o_mem_we      = mul_bus.we;
                o_mem_wdata   = mul_bus.wdata;
                mul_bus.rdata = i_mem_rdata;
            end
            default: ;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state       <= IDLE;
            add_start_q <= 1'b0;
            mul_start_q <= 1'b0;
        end else begin
            add_start_q <= 1'b0;
            mul_start_q <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept && i_req.op == OP_MUL) begin
                        state       <= RUN_MUL;
                        mul_start_q <= 1'b1;
                    end else if (accept) begin
                        state       <= RUN_ADD;
                        add_start_q <= 1'b1;
                    end
                end
                RUN_ADD: if (i_add_done) state <= RESPOND;
                RUN_MUL: if (i_mul_done) state <= RESPOND;
                RESPOND: if (i_rsp_ready) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) req_q <= i_req;
        if (unit_done) rsp_len_q <= rsp_len;
    end

endmodule

// ==== verilog/mul_unit.sv ====
`timescale 1ns/100ps

module mul_unit (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_start,
    input  bignum_pkg::op_req_t i_req,
    output logic                o_done,
    mem_bus_if.master           bus
);
    import bignum_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        LOAD_A,
        MUL,
        SUM,
        STORE,
        CARRY
    } state_e;

    state_e             state;
    logic               done_q;
    logic               first_row;
    len_t               row;
    len_t               col;
    len_t               row_nxt;
    len_t               col_nxt;
    logic               row_last;
    logic               col_last;
    word_t              a_word;
    logic [DWORD_W-1:0] acc;
    logic [DWORD_W-1:0] prod;
    addr_t              dst_pos;

    assign row_nxt  = row + len_t'(1);
    assign col_nxt  = col + len_t'(1);
    assign row_last = (row_nxt == i_req.a_len);
    assign col_last = (col_nxt == i_req.b_len);
    assign dst_pos  = i_req.dst_addr + addr_t'(row) + addr_t'(col);
    assign o_done   = done_q;

    // cannot overflow, even with the carry and the old dst word added.
    assign prod = DWORD_W'(bus.rdata) * DWORD_W'(a_word);

    always_comb begin
        bus.we    = 1'b0;
        bus.wdata = acc[WORD_W-1:0];
        bus.addr  = dst_pos;
        case (state)
            LOAD_A:       bus.addr = i_req.a_addr + addr_t'(row);
            MUL:          bus.addr = i_req.b_addr + addr_t'(col);
            STORE, CARRY: bus.we   = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state     <= IDLE;
            done_q    <= 1'b0;
            first_row <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                IDLE: begin
                    if (i_start) begin
                        state     <= LOAD_A;
                        first_row <= 1'b1;
                    end
                end
                LOAD_A: state <= MUL;
                MUL:    state <= first_row ? STORE : SUM; // row 0 has nothing to add.
                SUM:    state <= STORE;
                STORE:  state <= col_last ? CARRY : MUL;
                CARRY: begin
                    first_row <= 1'b0;
                    if (row_last) begin
                        state  <= IDLE;
                        done_q <= 1'b1;
                    end else begin
                        state <= LOAD_A;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        case (state)
            IDLE: if (i_start) row <= '0;
            LOAD_A: begin
                a_word <= bus.rdata;
                col    <= '0;
                acc    <= '0;
            end
            MUL: acc <= prod + acc;
            SUM: acc <= acc + DWORD_W'(bus.rdata);
            STORE: begin
                acc <= acc >> WORD_W;
                col <= col_nxt;
            end
            CARRY: row <= row_nxt; // carry word lands at dst + row + b_len.
            default: ;
        endcase
    end

endmodule

// ==== verilog/add_sub_unit.sv ====
`timescale 1ns/100ps

module add_sub_unit (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_start,
    input  logic                i_sub,
    input  bignum_pkg::op_req_t i_req,
    output logic                o_done,
    mem_bus_if.master           bus
);
    import bignum_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        READ_A,
        READ_B,
        STORE,
        CARRY
    } state_e;

    state_e          state;
    logic            done_q;
    logic            sub_q;
    len_t            idx;
    len_t            idx_nxt;
    len_t            n;
    logic            last;
    logic [WORD_W:0] acc;
    word_t           a_word;
    word_t           b_word;

    assign n       = (i_req.a_len > i_req.b_len) ? i_req.a_len : i_req.b_len;
    assign idx_nxt = idx + len_t'(1);
    assign last    = (idx_nxt == n);
    assign o_done  = done_q;

    // short operand is zero-extended.
    assign a_word = (idx < i_req.a_len) ? bus.rdata : '0;
    assign b_word = (idx < i_req.b_len) ? bus.rdata : '0;

    always_comb begin
        bus.we    = 1'b0;
        bus.wdata = acc[WORD_W-1:0];
        bus.addr  = i_req.dst_addr + addr_t'(idx);
        case (state)
            READ_A:       bus.addr = i_req.a_addr + addr_t'(idx);
            READ_B:       bus.addr = i_req.b_addr + addr_t'(idx);
            STORE, CARRY: bus.we   = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state  <= IDLE;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                IDLE:   if (i_start) state <= READ_A;
                READ_A: state <= READ_B;
                READ_B: state <= STORE;
                STORE: begin
                    if (!last) begin
                        state <= READ_A;
                    end else if (sub_q) begin
                        state  <= IDLE; // borrow out is dropped.
                        done_q <= 1'b1;
                    end else begin
                        state <= CARRY;
                    end
                end
                CARRY: begin
                    state  <= IDLE;
                    done_q <= 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        case (state)
            IDLE: begin
                if (i_start) begin
                    sub_q <= i_sub;
                    idx   <= '0;
                    acc   <= {{WORD_W{1'b0}}, i_sub}; // +1 completes ~b.
                end
            end
            READ_A: acc <= acc + {1'b0, a_word};
            READ_B: acc <= acc + {1'b0, (sub_q ? ~b_word : b_word)};
            STORE: begin
                acc <= {{WORD_W{1'b0}}, acc[WORD_W]};
                idx <= idx_nxt;
            end
            default: ;
        endcase
    end

endmodule

// ==== verilog/mem_bus_if.sv ====
`timescale 1ns/100ps

interface mem_bus_if;
    import bignum_pkg::*;

    addr_t addr;  // word address.
    logic  we;
    word_t wdata;
    word_t rdata; // valid in the same cycle as addr.

    modport master (
        output addr,
        output we,
        output wdata,
        input  rdata
    );

    modport arbiter (
        input  addr,
        input  we,
        input  wdata,
        output rdata
    );

endinterface

// ==== verilog/bignum_pkg.sv ====
package bignum_pkg;

    localparam int WORD_W  = 16;
    localparam int ADDR_W  = 20;
    localparam int LEN_W   = 8;
    localparam int DWORD_W = 2 * WORD_W; // product plus running carry.

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [LEN_W-1:0]  len_t;

    typedef enum logic [1:0] {
        OP_ADD,
        OP_SUB,
        OP_MUL
    } op_e;

    // operands are little-endian word arrays.
    typedef struct packed {
        op_e   op;
        addr_t a_addr;
        addr_t b_addr;
        addr_t dst_addr;
        len_t  a_len;
        len_t  b_len;
    } op_req_t;

endpackage
